/* design/riscv_pkg.sv */
// RV32I ISA definitions shared by the decode and register-read stages
// Widths, instruction word and the major opcode map

package riscv_pkg;

  localparam int XLEN = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] xlen_t; // Operands and immediates
  typedef logic [31:0] inst_t;
  typedef logic [XLEN-1:0] pc_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

  // Major opcode, instruction bits 6..2
  typedef enum logic [4:0] {
    LOAD   = 5'b00000,
    OP_IMM = 5'b00100,
    AUIPC  = 5'b00101,
    STORE  = 5'b01000,
    AMO    = 5'b01011,
    OP     = 5'b01100,
    LUI    = 5'b01101,
    BRANCH = 5'b11000,
    JALR   = 5'b11001,
    JAL    = 5'b11011
  } opcode_e;

endpackage

/* design/core_pkg.sv */
// Pipeline payloads and credit depths for the decode front end
// Depends on riscv_pkg for the ISA widths

package core_pkg;

  localparam int DECODE_SLOTS = 2;  // Also the fetch credit count
  localparam int QUEUE_DEPTH = 8;
  localparam int ISSUE_CREDITS = 2;

  localparam int SLOT_PTR_W = $clog2(DECODE_SLOTS);
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

  typedef logic [3:0] credit_cnt_t;

  // Only ADD for now, the rest of the ALU decode comes later
  typedef enum logic [3:0] {
    ADD = 4'd0
  } alu_cmd_e;

  typedef enum logic [1:0] {
    BRU_JAL  = 2'd0,
    BRU_JALR = 2'd1,
    BRU_BEQ  = 2'd2
  } bru_cmd_e;

  typedef struct packed {
    riscv_pkg::pc_t pc;
    riscv_pkg::reg_idx_t rs1;
    riscv_pkg::reg_idx_t rs2;
    riscv_pkg::reg_idx_t rd;
    riscv_pkg::xlen_t immediate;
    logic alu_cmd_vld;
    alu_cmd_e alu_cmd;
    logic bru_cmd_vld;
    bru_cmd_e bru_cmd;
  } dec_entry_t;

endpackage

/* design/frontend_links.sv */
// Credit-based links inside the front end
// The sender spends one credit per valid, the receiver pulses credit per freed slot
`timescale 1ns/1ps

interface fetch_link;
  logic valid;
  riscv_pkg::pc_t pc;
  riscv_pkg::inst_t inst;
  logic credit;

  modport sender (output valid, output pc, output inst, input credit);
  modport receiver (input valid, input pc, input inst, output credit);
endinterface

interface decode_link;
  logic valid;
  core_pkg::dec_entry_t entry;
  logic credit;

  modport sender (output valid, output entry, input credit);
  modport receiver (input valid, input entry, output credit);
endinterface

/* design/decoder.sv */
// RV32I decode stage, buffers fetched words and decodes the oldest one
// Sends decoded entries to the queue under queue credits
`timescale 1ns/1ps

module decoder (
  input logic clk,
  input logic rst,
  input logic invalidate,
  fetch_link.receiver fetch,
  decode_link.sender out
);

  logic [core_pkg::SLOT_PTR_W-1:0] wr_ptr, rd_ptr;
  core_pkg::credit_cnt_t slot_cnt;
  core_pkg::credit_cnt_t q_credits;  // Free entries in the queue
  riscv_pkg::pc_t slot_pc [core_pkg::DECODE_SLOTS];
  riscv_pkg::inst_t slot_inst [core_pkg::DECODE_SLOTS];

  logic push, send;
  riscv_pkg::inst_t inst;
  riscv_pkg::opcode_e opcode;
  logic base;
  logic rtype, itype, stype, btype, utype, jtype;
  core_pkg::dec_entry_t entry;

  assign push = fetch.valid && !invalidate;  // Words in flight during a flush are dropped
  assign send = (slot_cnt != '0) && (q_credits != '0) && !invalidate;

  always_comb begin
    inst = slot_inst[rd_ptr];
    opcode = riscv_pkg::opcode_e'(inst[6:2]);
    base = inst[1:0] == 2'b11;  // Compressed words get no command

    rtype = base && (opcode inside {riscv_pkg::AMO, riscv_pkg::OP});
    itype = base && (opcode inside {riscv_pkg::LOAD, riscv_pkg::OP_IMM, riscv_pkg::JALR});
    stype = base && (opcode == riscv_pkg::STORE);
    btype = base && (opcode == riscv_pkg::BRANCH);
    utype = base && (opcode inside {riscv_pkg::AUIPC, riscv_pkg::LUI});
    jtype = base && (opcode == riscv_pkg::JAL);

    entry = '0;
    entry.pc = slot_pc[rd_ptr];

    // Operand fields per format
    case (1'b1)
      rtype: begin
        entry.rs1 = inst[19:15];
        entry.rs2 = inst[24:20];
        entry.rd = inst[11:7];
      end
      itype: begin
        entry.rs1 = inst[19:15];
        entry.rd = inst[11:7];
        entry.immediate = {{20{inst[31]}}, inst[31:20]};
      end
      stype: begin
        entry.rs1 = inst[19:15];
        entry.rs2 = inst[24:20];
        entry.immediate = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      btype: begin
        entry.rs1 = inst[19:15];
        entry.rs2 = inst[24:20];
        entry.immediate = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      utype: begin
        entry.rd = inst[11:7];
        entry.immediate = {inst[31:12], 12'b0};
      end
      jtype: begin
        entry.rd = inst[11:7];
        entry.immediate = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: ;
    endcase

    // Commands
    entry.alu_cmd_vld = base && (opcode inside {riscv_pkg::OP_IMM, riscv_pkg::AUIPC,
                                                riscv_pkg::OP, riscv_pkg::LUI});
    entry.bru_cmd_vld = btype || jtype || (base && opcode == riscv_pkg::JALR);
    entry.alu_cmd = core_pkg::ADD;
    if (jtype) entry.bru_cmd = core_pkg::BRU_JAL;
    else if (entry.bru_cmd_vld && opcode == riscv_pkg::JALR) entry.bru_cmd = core_pkg::BRU_JALR;
    else if (btype) entry.bru_cmd = core_pkg::BRU_BEQ;
  end

  assign out.valid = send;
  assign out.entry = entry;
  assign fetch.credit = send;  // Slot frees as the entry leaves

  always_ff @(posedge clk) begin
    if (rst || invalidate) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      slot_cnt <= '0;
      q_credits <= core_pkg::credit_cnt_t'(core_pkg::QUEUE_DEPTH);
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (send) rd_ptr <= rd_ptr + 1'b1;
      slot_cnt <= slot_cnt + core_pkg::credit_cnt_t'(push) - core_pkg::credit_cnt_t'(send);
      q_credits <= q_credits + core_pkg::credit_cnt_t'(out.credit)
                 - core_pkg::credit_cnt_t'(send);
    end
  end

  // Slot storage
  always_ff @(posedge clk) begin
    if (push) begin
      slot_pc[wr_ptr] <= fetch.pc;
      slot_inst[wr_ptr] <= fetch.inst;
    end
  end

endmodule

/* design/decode_queue.sv */
// Decoded-entry FIFO between decode and register read
// Returns one credit to the decoder per pop, emptied by invalidate
`timescale 1ns/1ps

module decode_queue (
  input logic clk,
  input logic rst,
  input logic invalidate,
  decode_link.receiver in,
  input logic pop,
  output logic head_valid,
  output core_pkg::dec_entry_t head_entry
);

  core_pkg::dec_entry_t mem [core_pkg::QUEUE_DEPTH];
  logic [core_pkg::QUEUE_PTR_W-1:0] wr_ptr, rd_ptr;
  core_pkg::credit_cnt_t count;  // Occupancy, up to QUEUE_DEPTH
  logic wr_en, rd_en;

  assign wr_en = in.valid && !invalidate;
  assign rd_en = pop && head_valid;

  assign head_valid = count != '0;
  assign head_entry = mem[rd_ptr];
  assign in.credit = rd_en;  // Freed slot goes straight back

  always_ff @(posedge clk) begin
    if (rst || invalidate) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      count <= count + core_pkg::credit_cnt_t'(wr_en) - core_pkg::credit_cnt_t'(rd_en);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= in.entry;
  end

endmodule

/* design/regfile_read.sv */
// Register file and operand-read stage
// Pops the queue head under issue credits and registers the operation for execute
`timescale 1ns/1ps

module regfile_read (
  input logic clk,
  input logic rst,
  input logic invalidate,
  input logic head_valid,
  input core_pkg::dec_entry_t head_entry,
  output logic pop,
  input logic wb_en,
  input riscv_pkg::reg_idx_t wb_addr,
  input riscv_pkg::xlen_t wb_data,
  output logic issue_valid,
  output core_pkg::dec_entry_t issue_entry,
  output riscv_pkg::xlen_t rs1_data,
  output riscv_pkg::xlen_t rs2_data,
  input logic issue_credit
);

  riscv_pkg::xlen_t regs [riscv_pkg::NUM_REGS];
  core_pkg::credit_cnt_t credits;  // Free slots on the execute side
  riscv_pkg::xlen_t rs1_val, rs2_val;

  // x0 is hardwired, same-cycle writeback is bypassed
  function automatic riscv_pkg::xlen_t read_reg(input riscv_pkg::reg_idx_t idx);
    if (idx == '0) return '0;
    else if (wb_en && wb_addr == idx) return wb_data;
    else return regs[idx];
  endfunction

  assign pop = head_valid && (credits != '0) && !invalidate;

  always_comb begin
    rs1_val = read_reg(head_entry.rs1);
    rs2_val = read_reg(head_entry.rs2);
  end

  always_ff @(posedge clk) begin
    if (wb_en && wb_addr != '0) regs[wb_addr] <= wb_data;
  end

  // Execute still owns its entries across a flush, so credits survive invalidate
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= core_pkg::credit_cnt_t'(core_pkg::ISSUE_CREDITS);
      issue_valid <= 1'b0;
    end else begin
      credits <= credits + core_pkg::credit_cnt_t'(issue_credit)
               - core_pkg::credit_cnt_t'(pop);
      issue_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      issue_entry <= head_entry;
      rs1_data <= rs1_val;
      rs2_data <= rs2_val;
    end
  end

endmodule

/* design/frontend_top.sv */
// Front-end top level, decode then queue then register read
// Plain ports toward fetch, writeback and execute
`timescale 1ns/1ps

module frontend_top (
  input logic clk,
  input logic rst,
  input logic invalidate,
  input logic fetch_valid,
  input riscv_pkg::pc_t fetch_pc,
  input riscv_pkg::inst_t fetch_inst,
  output logic fetch_credit,
  input logic wb_en,
  input riscv_pkg::reg_idx_t wb_addr,
  input riscv_pkg::xlen_t wb_data,
  output logic issue_valid,
  output core_pkg::dec_entry_t issue_entry,
  output riscv_pkg::xlen_t rs1_data,
  output riscv_pkg::xlen_t rs2_data,
  input logic issue_credit
);

  fetch_link fetch_if ();
  decode_link dec_if ();

  logic head_valid;
  core_pkg::dec_entry_t head_entry;
  logic pop;

  // Fetch ports onto the link
  assign fetch_if.valid = fetch_valid;
  assign fetch_if.pc = fetch_pc;
  assign fetch_if.inst = fetch_inst;
  assign fetch_credit = fetch_if.credit;

  decoder u_decoder (
    .clk(clk),
    .rst(rst),
    .invalidate(invalidate),
    .fetch(fetch_if.receiver),
    .out(dec_if.sender)
  );

  decode_queue u_queue (
    .clk(clk),
    .rst(rst),
    .invalidate(invalidate),
    .in(dec_if.receiver),
    .pop(pop),
    .head_valid(head_valid),
    .head_entry(head_entry)
  );

  regfile_read u_regfile_read (
    .clk(clk),
    .rst(rst),
    .invalidate(invalidate),
    .head_valid(head_valid),
    .head_entry(head_entry),
    .pop(pop),
    .wb_en(wb_en),
    .wb_addr(wb_addr),
    .wb_data(wb_data),
    .issue_valid(issue_valid),
    .issue_entry(issue_entry),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .issue_credit(issue_credit)
  );

endmodule

/* test/tb_clock.sv */
// Free-running testbench clock, 4 ns period
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);
  initial clk = 1'b0;
  always #2 clk = ~clk;
endmodule

/* test/tb_frontend.sv */
// Testbench for the decode front end, replays the golden file through the DUT
// Every issued operation is checked in order against the expected records
`timescale 1ns/1ps

module tb_frontend;

  logic clk, rst, invalidate, fetch_valid, fetch_credit, wb_en, issue_valid;
  logic issue_credit = 1'b0;
  riscv_pkg::pc_t fetch_pc;
  riscv_pkg::inst_t fetch_inst;
  riscv_pkg::reg_idx_t wb_addr;
  riscv_pkg::xlen_t wb_data, rs1_data, rs2_data;
  core_pkg::dec_entry_t issue_entry;

  core_pkg::dec_entry_t exp_entry [$];
  riscv_pkg::xlen_t exp_rs1 [$], exp_rs2 [$];
  int ret_delay [$];  // Random credit return delays, drawn in send order
  int ret_due [$];  // Cycles at which an issue credit goes back
  int cycle = 0;
  int max_cycles = 100000;
  int fetch_credits, errors, tests, failed;

  tb_clock u_clock (.clk(clk));

  frontend_top uut (.*);

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_drain();
    while (exp_entry.size() != 0) step();
  endtask

  task automatic send_inst(input riscv_pkg::inst_t inst, input core_pkg::dec_entry_t exp,
                           input riscv_pkg::xlen_t d1, input riscv_pkg::xlen_t d2);
    while (fetch_credits == 0) step();
    fetch_valid = 1'b1;
    fetch_pc = exp.pc;
    fetch_inst = inst;
    fetch_credits--;
    exp_entry.push_back(exp);
    exp_rs1.push_back(d1);
    exp_rs2.push_back(d2);
    ret_delay.push_back(int'($urandom % 6));
    step();
    fetch_valid = 1'b0;
  endtask

  // Anything not issued by the flush edge is gone
  task automatic flush();
    invalidate = 1'b1;
    step();
    invalidate = 1'b0;
    exp_entry.delete();
    exp_rs1.delete();
    exp_rs2.delete();
    fetch_credits = core_pkg::DECODE_SLOTS;
  endtask

  // Cycle count, watchdog and delayed issue credit return
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > max_cycles) begin
      $display("Timeout after %0d cycles, %0d issues never arrived", cycle, exp_entry.size());
      $display("Finished with errors");
      $finish;
    end else begin
      #1;
      issue_credit = 1'b0;
      if (ret_due.size() > 0 && ret_due[0] <= cycle) begin
        void'(ret_due.pop_front());
        issue_credit = 1'b1;
      end
    end
  end

  // Mid-cycle sampling of fetch credits and issues
  always @(negedge clk) begin
    if (fetch_credit) begin
      fetch_credits = fetch_credits + 1;
      if (fetch_credits > core_pkg::DECODE_SLOTS) begin
        $display("Fetch credit count went above %0d at %0t", core_pkg::DECODE_SLOTS, $time);
        errors++;
      end
    end
    if (issue_valid) begin
      if (ret_delay.size() > 0) ret_due.push_back(cycle + ret_delay.pop_front());
      else ret_due.push_back(cycle);
      if (exp_entry.size() == 0) begin
        $display("Unexpected issue of pc %h at %0t", issue_entry.pc, $time);
        errors++;
      end else begin
        if (issue_entry !== exp_entry[0]) begin
          $display("Mismatch at %0t: entry %h, expected %h", $time, issue_entry, exp_entry[0]);
          errors++;
        end
        if (rs1_data !== exp_rs1[0] || rs2_data !== exp_rs2[0]) begin
          $display("Mismatch at %0t: pc %h operands %h %h, expected %h %h", $time,
                   issue_entry.pc, rs1_data, rs2_data, exp_rs1[0], exp_rs2[0]);
          errors++;
        end
        void'(exp_entry.pop_front());
        void'(exp_rs1.pop_front());
        void'(exp_rs2.pop_front());
      end
    end
  end

  initial begin
    int fd, n, err_mark;
    byte kind;
    logic [8*128-1:0] line, name;
    logic [31:0] f [11];
    core_pkg::dec_entry_t exp;
    void'($urandom(32'h0fffe574));
    {rst, invalidate, fetch_valid, wb_en} = 4'b1000;
    fetch_pc = '0;
    fetch_inst = '0;
    wb_addr = '0;
    wb_data = '0;
    {errors, tests, failed, err_mark, fetch_credits} = '0;
    fd = $fopen("test/frontend_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/frontend_golden.txt");
      $display("Finished with errors");
      $finish;
    end else begin
      n = 0;
      while ($fgets(line, fd) > 0) n++;
      max_cycles = 40 * n + 200;  // Run limit from the golden length
      $fclose(fd);
      fd = $fopen("test/frontend_golden.txt", "r");
      repeat (16) @(posedge clk);
      #1 rst = 1'b0;
      fetch_credits = core_pkg::DECODE_SLOTS;
      while ($fscanf(fd, " %c", kind) == 1) begin
        case (kind)
          "#": n = $fgets(line, fd);
          "W": begin
            n = $fscanf(fd, "%h %h", f[0], f[1]);
            wait_drain();
            wb_en = 1'b1;
            wb_addr = f[0][4:0];
            wb_data = f[1];
            step();
            wb_en = 1'b0;
          end
          "I": begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                        f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
            exp = '0;
            exp.pc = f[0];
            exp.rs1 = f[2][4:0];
            exp.rs2 = f[3][4:0];
            exp.rd = f[4][4:0];
            exp.immediate = f[5];
            exp.alu_cmd_vld = f[6][0];
            exp.alu_cmd = core_pkg::ADD;  // Only ALU op in this core
            exp.bru_cmd_vld = f[7][0];
            exp.bru_cmd = core_pkg::bru_cmd_e'(f[8][1:0]);
            send_inst(f[1], exp, f[9], f[10]);
          end
          "F": flush();
          "T": begin
            n = $fscanf(fd, "%s", name);
            wait_drain();
            tests++;
            if (errors == err_mark) $display("Test %0s passed", name);
            else begin
              failed++;
              $display("Test %0s failed with %0d errors", name, errors - err_mark);
            end
            err_mark = errors;
          end
          default: begin
            $display("Unknown golden record type %c", kind);
            errors++;
          end
        endcase
      end
      $fclose(fd);
      $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
      if (errors == 0) $display("Finished with no errors");
      else $display("Finished with errors");
      $finish;
    end
  end

endmodule

/* build.f */
design/riscv_pkg.sv
design/core_pkg.sv
design/frontend_links.sv
design/decoder.sv
design/decode_queue.sv
design/regfile_read.sv
design/frontend_top.sv
test/tb_clock.sv
test/tb_frontend.sv

/* Bender.yml */
package:
  name: rv32i_frontend

sources:
  - design/riscv_pkg.sv
  - design/core_pkg.sv
  - design/frontend_links.sv
  - design/decoder.sv
  - design/decode_queue.sv
  - design/regfile_read.sv
  - design/frontend_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_frontend.sv

/* test/frontend_golden.txt */
# W addr data | I pc inst rs1 rs2 rd imm alu_vld bru_vld bru_cmd rs1_data rs2_data
# F flushes the pipeline, T name ends a test; all numbers in hex
W 01 11111111
W 02 22222222
W 00 deadbeef
I 00001000 fff08193 01 00 03 ffffffff 1 0 0 11111111 00000000
I 00001004 fe20ae23 01 02 00 fffffffc 0 0 0 11111111 22222222
I 00001008 fe2088e3 01 02 00 fffffff0 0 1 2 11111111 22222222
I 0000100c 123452b7 00 00 05 12345000 1 0 0 00000000 00000000
I 00001010 fffff317 00 00 06 fffff000 1 0 0 00000000 00000000
I 00001014 ff9ff0ef 00 00 01 fffffff8 0 1 0 00000000 00000000
I 00001018 00008067 01 00 00 00000000 0 1 1 11111111 00000000
T formats
I 0000101c 002083b3 01 02 07 00000000 1 0 0 11111111 22222222
I 00001020 00412403 02 00 08 00000004 0 0 0 22222222 00000000
I 00001024 0020a4af 01 02 09 00000000 0 0 0 11111111 22222222
I 00001028 00000073 00 00 00 00000000 0 0 0 00000000 00000000
I 0000102c 00100533 00 01 0a 00000000 1 0 0 00000000 11111111
T classify_and_operands
I 00002000 fff08193 01 00 03 ffffffff 1 0 0 11111111 00000000
I 00002004 fff08193 01 00 03 ffffffff 1 0 0 11111111 00000000
I 00002008 fff08193 01 00 03 ffffffff 1 0 0 11111111 00000000
F
I 00003000 002083b3 01 02 07 00000000 1 0 0 11111111 22222222
I 00003004 123452b7 00 00 05 12345000 1 0 0 00000000 00000000
T invalidate
